// ==== compile.f ====
+incdir+.
lsu_pkg.sv
lsu_req_align.sv
lsu_access_seq.sv
lsu_rdata_align.sv
lsu_top.sv
tb_lsu_top.sv

// ==== tb_lsu_top.sv ====
/*
  directed testbench of the load store unit with a byte-addressed bus model
  the bus memory wraps at 256 bytes and writes land even on a flagged error
  delays of grant and response are random only where a test enables them
*/
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

  import lsu_pkg::*;

  localparam int          CLK_PERIOD = 100;          // ns
  localparam int          TIMEOUT    = 50;           // cycles per wait
  localparam int          MEM_DEPTH  = 256;          // bytes, multiple of 4
  localparam logic [31:0] SEED       = 32'hc59a_f9a0;

  typedef struct packed {
    lsu_word_t   rdata;
    logic        err;
    logic [31:0] ready; // first cycle the beat may return
  } resp_t;

  logic         clk_i, rst_ni;
  logic         data_req_ex_i;
  lsu_ex_req_t  ex_req_i;
  lsu_word_t    data_rdata_ex_o, addr_last_o, data_rdata_i;
  logic         addr_incr_req_o, data_valid_o, load_err_o, store_err_o, busy_o;
  logic         data_req_o, data_gnt_i, data_rvalid_i, data_err_i;
  lsu_bus_req_t bus_req_o;

  logic [7:0]   mem [MEM_DEPTH];     // bus side memory
  logic [7:0]   ref_mem [MEM_DEPTH]; // expected contents
  resp_t        resp_q[$];           // in order, at most two
  lsu_bus_req_t bus_log[$];          // requests granted in the current access
  logic         incr_log[$];         // addr_incr_req_o at each grant
  int           bus_items, err_item; // error goes on item number err_item
  logic         rand_delay;
  string        cur_test;
  int           checks, errors, test_errs, tests_run, tests_failed;

  lsu_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////
  // result bookkeeping
  ////////////////////////////////

  task automatic tally(input bit ok);
    checks++;
    if (!ok) begin
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_word(input string what, input lsu_word_t got, input lsu_word_t exp);
    tally(got === exp);
    if (got !== exp) $display("Fail %0t ns: %s in %s, got %h expected %h",
                              $time, what, cur_test, got, exp);
  endtask

  task automatic check_bus(input string what, input lsu_bus_req_t got,
                           input lsu_bus_req_t exp);
    tally(got === exp);
    if (got !== exp) begin
      $display("Fail %0t ns: %s in %s, got %h/%b/%b/%h expected %h/%b/%b/%h", $time, what,
               cur_test, got.addr, got.we, got.be, got.wdata,
               exp.addr, exp.we, exp.be, exp.wdata);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    tally(got === exp);
    if (got !== exp) $display("Fail %0t ns: %s in %s, got %b expected %b",
                              $time, what, cur_test, got, exp);
  endtask

  task automatic finish_run();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic abort_run(input string why);
    $display("Timeout at %0t ns in %s: %s", $time, cur_test, why);
    errors++;
    finish_run();
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %-8s %s, %0d errors", cur_test, (test_errs != 0) ? "failed" : "ok",
             test_errs);
  endtask

  ////////////////////////////////
  // expected values
  ////////////////////////////////

  function automatic int mem_index(input lsu_word_t a);
    return int'(a % MEM_DEPTH);
  endfunction

  function automatic logic [7:0] fill_byte(input int i);
    return 8'(i * 13 + 91); // every address bit matters
  endfunction

  function automatic int access_bytes(input lsu_type_e t);
    case (t)
      LSU_WORD: return 4;
      LSU_HALF: return 2;
      default:  return 1; // both byte codes
    endcase
  endfunction

  // split when the last byte falls into the next word
  function automatic bit crosses_word(input lsu_ex_req_t req);
    return (int'(req.addr[1:0]) + access_bytes(req.dtype)) > 4;
  endfunction

  function automatic lsu_bus_req_t exp_bus(input lsu_ex_req_t req, input int part);
    lsu_bus_req_t b;
    int           offs, pos, k;
    offs   = req.addr[1:0];
    b.addr = {req.addr[31:2], 2'b00} + ((part != 0) ? 32'd4 : 32'd0);
    b.we   = req.we;
    b.be   = '0;
    for (k = 0; k < access_bytes(req.dtype); k++) begin
      pos = offs + k;
      if ((pos >= 4) == (part != 0)) b.be[pos % 4] = 1'b1; // byte k lands in this part
    end
    for (k = 0; k < 4; k++) b.wdata[((offs + k) % 4) * 8 +: 8] = req.wdata[k * 8 +: 8];
    return b;
  endfunction

  function automatic lsu_word_t exp_load(input lsu_ex_req_t req);
    lsu_word_t v;
    int        n, k;
    n = access_bytes(req.dtype);
    v = '0;
    for (k = 0; k < n; k++) v[k * 8 +: 8] = ref_mem[mem_index(req.addr + k)]; // little endian
    if (req.sign_ext && n < 4 && v[n * 8 - 1]) v = v | (32'hffff_ffff << (n * 8));
    return v;
  endfunction

  task automatic store_shadow(input lsu_ex_req_t req);
    int k;
    for (k = 0; k < access_bytes(req.dtype); k++) begin
      ref_mem[mem_index(req.addr + k)] = req.wdata[k * 8 +: 8];
    end
  endtask

  function automatic lsu_ex_req_t make_req(input logic we, input lsu_type_e t,
                                           input logic sx, input lsu_word_t a,
                                           input lsu_word_t d);
    lsu_ex_req_t r;
    r.we       = we;
    r.dtype    = t;
    r.sign_ext = sx;
    r.wdata    = d;
    r.addr     = a;
    return r;
  endfunction

  ////////////////////////////////
  // bus memory model
  ////////////////////////////////

  task automatic take_request(input logic [31:0] now);
    lsu_word_t rd;
    resp_t     r;
    int        lane;
    for (lane = 0; lane < 4; lane++) begin
      if (bus_req_o.we && bus_req_o.be[lane]) begin
        mem[mem_index(bus_req_o.addr + lane)] = bus_req_o.wdata[lane * 8 +: 8];
      end
      rd[lane * 8 +: 8] = mem[mem_index(bus_req_o.addr + lane)];
    end
    r.rdata = rd;
    r.err   = (bus_items == err_item);
    r.ready = now + (rand_delay ? $urandom_range(3, 1) : 1); // never in the grant cycle
    resp_q.push_back(r);
    bus_log.push_back(bus_req_o);
    incr_log.push_back(addr_incr_req_o);
    bus_items++;
  endtask

  // samples on the rising edge, drives on the falling edge
  initial begin : bus_model
    lsu_bus_req_t held;
    logic         held_v;
    logic [31:0]  cyc;
    int unsigned  gnt_cnt;
    resp_t        r;
    held_v  = 1'b0;
    cyc     = '0;
    gnt_cnt = 0;
    forever begin
      @(posedge clk_i);
      if (held_v) begin
        check_flag("data_req_o held until grant", data_req_o, 1'b1);
        check_bus("bus_req_o held until grant", bus_req_o, held);
      end
      held_v = data_req_o && !data_gnt_i;
      held   = bus_req_o;
      if (data_req_o && data_gnt_i) begin
        take_request(cyc);
        gnt_cnt = rand_delay ? $urandom_range(3, 0) : 0;
      end else if (data_req_o && gnt_cnt > 0) begin
        gnt_cnt--; // delay runs only while requested
      end
      cyc++;
      @(negedge clk_i);
      data_gnt_i = (gnt_cnt == 0);
      if (resp_q.size() > 0 && resp_q[0].ready <= cyc) begin
        r             = resp_q.pop_front();
        data_rvalid_i = 1'b1;
        data_rdata_i  = r.rdata;
        data_err_i    = r.err;
      end else begin
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        data_err_i    = 1'b0;
      end
    end
  end

  ////////////////////////////////
  // execute stage side
  ////////////////////////////////

  // core presents the next word base once for the second part
  task automatic answer_addr_incr(inout logic incr_done);
    if (addr_incr_req_o && !incr_done) begin
      ex_req_i.addr = {addr_last_o[31:2], 2'b00} + 32'd4;
      incr_done     = 1'b1;
    end
  endtask

  task automatic run_access(input lsu_ex_req_t req, output lsu_word_t rdata,
                            output logic lerr, output logic serr, output lsu_word_t alast);
    int   cnt;
    logic done, incr_done;
    cnt       = 0;
    done      = 1'b0;
    incr_done = 1'b0;
    bus_log.delete();
    incr_log.delete();
    @(negedge clk_i);
    ex_req_i      = req;
    data_req_ex_i = 1'b1;
    while (!done) begin
      @(posedge clk_i);
      if (cnt > 0) check_flag("busy_o during access", busy_o, 1'b1);
      if (data_valid_o) begin
        rdata = data_rdata_ex_o;
        lerr  = load_err_o;
        serr  = store_err_o;
        done  = 1'b1;
      end else begin
        check_flag("error only with data_valid_o", load_err_o | store_err_o, 1'b0);
      end
      @(negedge clk_i);
      if (done) data_req_ex_i = 1'b0;
      else answer_addr_incr(incr_done);
      cnt++;
      if (cnt > TIMEOUT) abort_run("data_valid_o never came");
    end
    alast = addr_last_o;
    @(posedge clk_i);
    check_flag("data_valid_o pulses once", data_valid_o, 1'b0);
    check_flag("busy_o after access", busy_o, 1'b0);
  endtask

  task automatic check_access(input lsu_ex_req_t req);
    lsu_word_t rdata, alast, exp_rd, base;
    logic      lerr, serr;
    int        parts, p;
    parts  = crosses_word(req) ? 2 : 1;
    exp_rd = exp_load(req);
    base   = {req.addr[31:2], 2'b00};
    run_access(req, rdata, lerr, serr, alast);
    check_word("bus request count", 32'(bus_log.size()), 32'(parts));
    if (bus_log.size() == parts) begin
      for (p = 0; p < parts; p++) begin
        check_bus("bus request", bus_log[p], exp_bus(req, p));
        check_flag("addr_incr_req_o at grant", incr_log[p], p == 1);
      end
    end
    check_flag("load_err_o", lerr, 1'b0);
    check_flag("store_err_o", serr, 1'b0);
    check_word("addr_last_o", alast, (parts == 2) ? base + 32'd4 : req.addr);
    if (req.we) store_shadow(req);
    else check_word("load data", rdata, exp_rd);
  endtask

  task automatic round_trip(input lsu_type_e t, input lsu_word_t a);
    lsu_word_t d;
    d = $urandom() | 32'h0000_8080; // top bit set in the low byte and half
    check_access(make_req(1'b1, t, 1'b0, a, d));
    check_access(make_req(1'b0, t, 1'b0, a, '0));
    check_access(make_req(1'b0, t, 1'b1, a, '0));
  endtask

  task automatic check_error(input lsu_ex_req_t req, input int part);
    lsu_word_t rdata, alast;
    logic      lerr, serr;
    err_item = bus_items + part;
    run_access(req, rdata, lerr, serr, alast);
    err_item = -1;
    check_flag("load_err_o", lerr, !req.we);
    check_flag("store_err_o", serr, req.we);
    check_word("addr_last_o", alast, (part == 0) ? req.addr : {req.addr[31:2], 2'b00} + 32'd4);
    if (req.we) store_shadow(req);
  endtask

  ////////////////////////////////
  // tests
  ////////////////////////////////

  task automatic test_reset();
    begin_test("reset");
    @(posedge clk_i);
    check_flag("data_req_o", data_req_o, 1'b0);
    check_flag("data_valid_o", data_valid_o, 1'b0);
    check_flag("addr_incr_req_o", addr_incr_req_o, 1'b0);
    check_flag("load_err_o", load_err_o, 1'b0);
    check_flag("store_err_o", store_err_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    check_word("addr_last_o", addr_last_o, '0);
    end_test();
  endtask

  task automatic test_aligned();
    int k;
    begin_test("aligned");
    round_trip(LSU_WORD, 32'h40);
    round_trip(LSU_HALF, 32'h48);
    round_trip(LSU_HALF, 32'h4a);
    for (k = 0; k < 4; k++) round_trip((k % 2) ? LSU_BYTE_HI : LSU_BYTE, 32'h50 + k);
    end_test();
  endtask

  task automatic test_split();
    begin_test("split");
    round_trip(LSU_WORD, 32'h61);
    round_trip(LSU_WORD, 32'h66);
    round_trip(LSU_WORD, 32'h6b);
    round_trip(LSU_HALF, 32'h73);
    round_trip(LSU_HALF, 32'h79); // offset 1 stays in one word
    end_test();
  endtask

  task automatic test_random();
    int n;
    begin_test("random");
    rand_delay = 1'b1;
    for (n = 0; n < 40; n++) begin
      check_access(make_req(1'($urandom_range(1, 0)), lsu_type_e'($urandom_range(3, 0)),
                            1'($urandom_range(1, 0)), 32'h80 + $urandom_range(63, 0),
                            $urandom()));
    end
    end_test();
  endtask

  task automatic test_errors();
    int k;
    begin_test("errors");
    for (k = 0; k < 2; k++) begin // loads, then stores
      check_error(make_req(k[0], LSU_WORD, 1'b0, 32'hc0, $urandom()), 0);
      check_error(make_req(k[0], LSU_WORD, 1'b0, 32'hc5, $urandom()), 0);
      check_error(make_req(k[0], LSU_WORD, 1'b0, 32'hc5, $urandom()), 1);
      check_error(make_req(k[0], LSU_HALF, 1'b1, 32'hc3, $urandom()), 1);
    end
    check_access(make_req(1'b0, LSU_WORD, 1'b0, 32'hc4, '0)); // error state cleared
    end_test();
  endtask

  initial begin : main
    int i;
    void'($urandom(SEED));
    rst_ni        = 1'b0;
    data_req_ex_i = 1'b0;
    ex_req_i      = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    rand_delay    = 1'b0;
    err_item      = -1;
    bus_items     = 0;
    checks        = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    for (i = 0; i < MEM_DEPTH; i++) begin
      mem[i]     = fill_byte(i);
      ref_mem[i] = fill_byte(i);
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    test_aligned();
    test_split();
    test_random();
    test_errors();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
/*
  load store unit between the execute stage and a req/gnt/rvalid data bus
  misaligned accesses go out as two word-aligned bus requests
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  // execute stage
  input  wire                       data_req_ex_i,
  input  wire lsu_pkg::lsu_ex_req_t ex_req_i,
  output lsu_pkg::lsu_word_t        data_rdata_ex_o,
  output logic                      addr_incr_req_o,
  output lsu_pkg::lsu_word_t        addr_last_o,     // trap value
  output logic                      data_valid_o,
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      busy_o,
  // data bus
  output logic                      data_req_o,
  input  wire                       data_gnt_i,
  input  wire                       data_rvalid_i,
  input  wire                       data_err_i,
  input  wire lsu_pkg::lsu_word_t   data_rdata_i,
  output lsu_pkg::lsu_bus_req_t     bus_req_o
);

  import lsu_pkg::*;

  logic      split;
  logic      second_part;
  logic      ctrl_update;
  logic      rdata_update;
  lsu_ctrl_t ctrl;

  lsu_req_align u_req_align (
    .ex_req_i      (ex_req_i),
    .second_part_i (second_part),
    .addr_last_i   (addr_last_o),  // first part offset during the second part
    .bus_req_o     (bus_req_o),
    .split_o       (split)
  );

  lsu_access_seq u_access_seq (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_req_ex_i   (data_req_ex_i),
    .ex_req_i        (ex_req_i),
    .split_i         (split),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_err_i),
    .data_req_o      (data_req_o),
    .addr_incr_req_o (addr_incr_req_o),
    .data_valid_o    (data_valid_o),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o),
    .second_part_o   (second_part),
    .ctrl_update_o   (ctrl_update),
    .ctrl_o          (ctrl),
    .rdata_update_o  (rdata_update),
    .addr_last_o     (addr_last_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .data_rdata_i   (data_rdata_i),
    .ctrl_update_i  (ctrl_update),
    .ctrl_i         (ctrl),
    .rdata_update_i (rdata_update),
    .rdata_o        (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

// ==== lsu_rdata_align.sv ====
/*
  read side of the load store unit
  rdata_o is only meaningful in the cycle of the final rvalid
  the beat register holds lanes 1..3 of the first beat of a split load
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_rdata_align (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire lsu_pkg::lsu_word_t data_rdata_i,   // current bus beat
  input  wire                     ctrl_update_i,  // first part granted
  input  wire lsu_pkg::lsu_ctrl_t ctrl_i,
  input  wire                     rdata_update_i, // first beat of a split load
  output lsu_pkg::lsu_word_t      rdata_o
);

  import lsu_pkg::*;

  lsu_ctrl_t   ctrl_q;
  logic [31:8] rdata_q;   // lane 0 of the first beat is never needed
  lsu_word_t   word_al;   // realigned word
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      ctrl_q <= ctrl_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  ////////////////////////////////
  // lane selection
  ////////////////////////////////

  // split words take the high lanes of the first beat as their low bytes
  always_comb begin
    unique case (ctrl_q.offs)
      2'd0:    word_al = data_rdata_i;
      2'd1:    word_al = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2:    word_al = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3:    word_al = {data_rdata_i[23:0], rdata_q[31:24]};
      default: word_al = data_rdata_i;
    endcase
  end

  always_comb begin
    unique case (ctrl_q.offs)
      2'd0:    half_sel = data_rdata_i[15:0];
      2'd1:    half_sel = data_rdata_i[23:8];
      2'd2:    half_sel = data_rdata_i[31:16];
      2'd3:    half_sel = {data_rdata_i[7:0], rdata_q[31:24]}; // the only split half
      default: half_sel = data_rdata_i[15:0];
    endcase
  end

  assign byte_sel = data_rdata_i[{ctrl_q.offs, 3'b000} +: 8]; // bytes never split

  ////////////////////////////////
  // extension
  ////////////////////////////////

  always_comb begin
    unique case (ctrl_q.dtype)
      LSU_WORD: rdata_o = word_al;
      LSU_HALF: rdata_o = {{16{ctrl_q.sign_ext & half_sel[15]}}, half_sel};
      LSU_BYTE, LSU_BYTE_HI: begin
        rdata_o = {{24{ctrl_q.sign_ext & byte_sel[7]}}, byte_sel};
      end
      default: rdata_o = word_al;
    endcase
  end

endmodule

`default_nettype wire

// ==== lsu_access_seq.sv ====
/*
  sequencer of the load store unit, one access at a time
  up to two bus items in flight; responses must come back in order
  the execute stage must keep its request steady until data_valid_o
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_access_seq (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire                       data_req_ex_i,
  input  wire lsu_pkg::lsu_ex_req_t ex_req_i,
  input  wire                       split_i,        // from the request side
  input  wire                       data_gnt_i,
  input  wire                       data_rvalid_i,
  input  wire                       data_err_i,     // only with rvalid
  output logic                      data_req_o,
  output logic                      addr_incr_req_o, // core to present next word
  output logic                      data_valid_o,
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      busy_o,
  output logic                      second_part_o,
  output logic                      ctrl_update_o,   // read side loads ctrl_o
  output lsu_pkg::lsu_ctrl_t        ctrl_o,
  output logic                      rdata_update_o,  // read side keeps first beat
  output lsu_pkg::lsu_word_t        addr_last_o
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID, WAIT_RVALID_DONE
  } ls_state_e;

  ls_state_e state_q, state_d;
  logic      mis_q, mis_d;       // second part is being handled
  logic      err_q, err_d;       // first part came back with an error
  logic      we_q;               // store in flight
  logic      addr_update;
  logic      err_any;            // error of the completing access
  lsu_word_t addr_last_q;

  // control of the access as presented, only sampled on a first-part grant
  assign ctrl_o.offs     = ex_req_i.addr[1:0];
  assign ctrl_o.dtype    = ex_req_i.dtype;
  assign ctrl_o.sign_ext = ex_req_i.sign_ext;

  ////////////////////////////////
  // state machine
  ////////////////////////////////

  always_comb begin
    state_d         = state_q;
    mis_d           = mis_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    data_valid_o    = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;
    err_any         = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (data_req_ex_i) begin
          data_req_o = 1'b1;  // straight through, no cycle lost
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            mis_d         = split_i;
            state_d       = split_i ? WAIT_RVALID_MIS : WAIT_RVALID;
          end else begin
            state_d       = split_i ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          mis_d         = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      // first part out, second part requested while waiting for its beat
      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          addr_update    = data_gnt_i & ~data_err_i; // keep the failing address
          state_d        = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end else if (data_gnt_i) begin
          state_d = WAIT_RVALID_DONE; // both parts in flight
        end
      end

      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = mis_q;
        if (data_gnt_i) begin
          ctrl_update_o = ~mis_q; // the second part shows a word base offset
          addr_update   = ~err_q;
          state_d       = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (data_rvalid_i) begin
          data_valid_o = 1'b1;
          err_any      = err_q | data_err_i; // either part
          mis_d        = 1'b0;
          state_d      = IDLE;
        end
      end

      // second part granted before the first beat returned
      WAIT_RVALID_DONE: begin
        addr_incr_req_o = 1'b1; // keeps the second address on the bus side
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~we_q;
          state_d        = WAIT_RVALID;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////
  // registers
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      mis_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      mis_q   <= mis_d;
      err_q   <= err_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_update_o) begin
      we_q <= ex_req_i.we;
    end
  end

  // trap value and base for the second part
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= ex_req_i.addr;
    end
  end

  assign addr_last_o   = addr_last_q;
  assign second_part_o = mis_q;
  assign load_err_o    = err_any & ~we_q;
  assign store_err_o   = err_any & we_q;
  assign busy_o        = (state_q != IDLE);

endmodule

`default_nettype wire

// ==== lsu_req_align.sv ====
/*
  request side of the load store unit, purely combinational
  in the second part of a split access the core presents the word base of the
  next word, so the lane offset is taken from the last granted address instead
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_req_align (
  input  wire lsu_pkg::lsu_ex_req_t  ex_req_i,      // held by the execute stage
  input  wire                        second_part_i, // second half of a split access
  input  wire lsu_pkg::lsu_word_t    addr_last_i,   // address of the first part
  output lsu_pkg::lsu_bus_req_t      bus_req_o,
  output logic                       split_o        // access crosses a word boundary
);

  import lsu_pkg::*;

  lsu_offs_t offs_ex;   // offset as presented now
  lsu_offs_t offs;      // offset of the whole access
  lsu_be_t   be;
  lsu_word_t wdata_rot;

  assign offs_ex = ex_req_i.addr[`LSU_OFFS_W-1:0];
  assign offs    = second_part_i ? addr_last_i[`LSU_OFFS_W-1:0] : offs_ex;

  ////////////////////////////////
  // byte enables
  ////////////////////////////////

  always_comb begin
    unique case (ex_req_i.dtype)
      LSU_WORD: begin
        if (!second_part_i) begin
          be = lsu_be_t'({`LSU_BE_W{1'b1}} << offs);   // upper lanes of first word
        end else begin
          be = lsu_be_t'(~({`LSU_BE_W{1'b1}} << offs)); // spill into low lanes
        end
      end
      LSU_HALF: begin
        if (!second_part_i) begin
          be = lsu_be_t'(4'b0011 << offs); // offset 3 keeps only lane 3
        end else begin
          be = 4'b0001;                     // only a half at offset 3 gets here
        end
      end
      LSU_BYTE, LSU_BYTE_HI: begin
        be = lsu_be_t'(4'b0001 << offs);    // never split
      end
      default: be = '0;
    endcase
  end

  ////////////////////////////////
  // store data lanes
  ////////////////////////////////

  // rotate left by whole bytes, both parts see the same rotated word
  always_comb begin
    unique case (offs)
      2'd0:    wdata_rot = ex_req_i.wdata;
      2'd1:    wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      2'd3:    wdata_rot = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
      default: wdata_rot = ex_req_i.wdata;
    endcase
  end

  assign bus_req_o.addr  = {ex_req_i.addr[`LSU_ADDR_W-1:`LSU_OFFS_W], {`LSU_OFFS_W{1'b0}}};
  assign bus_req_o.we    = ex_req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

  // words off the word base and halves in the last lane need two bus beats
  assign split_o = ((ex_req_i.dtype == LSU_WORD) && (offs_ex != '0)) ||
                   ((ex_req_i.dtype == LSU_HALF) && (offs_ex == 2'd3));

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
/*
  shared types of the load store unit
  access size codes follow the core decoder: 00 word, 01 half, 1x byte
*/
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

  typedef logic [`LSU_DATA_W-1:0] lsu_word_t; // data or address word
  typedef logic [`LSU_BE_W-1:0]   lsu_be_t;   // byte enables
  typedef logic [`LSU_OFFS_W-1:0] lsu_offs_t; // byte offset in a word

  // access size, two codes for byte as the decoder leaves bit 0 free
  typedef enum logic [1:0] {
    LSU_WORD    = 2'b00,
    LSU_HALF    = 2'b01,
    LSU_BYTE    = 2'b10,
    LSU_BYTE_HI = 2'b11
  } lsu_type_e;

  // request from the execute stage, held until data_valid
  typedef struct packed {
    logic                   we;       // store when set
    lsu_type_e              dtype;    // access size
    logic                   sign_ext; // sign-extend loads
    lsu_word_t              wdata;    // store data, unrotated
    logic [`LSU_ADDR_W-1:0] addr;     // byte address
  } lsu_ex_req_t;

  // fields sampled by the bus on a grant
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;  // always word aligned
    logic                   we;
    lsu_be_t                be;
    lsu_word_t              wdata; // already on its byte lanes
  } lsu_bus_req_t;

  // what the read side must remember of an access
  typedef struct packed {
    lsu_offs_t offs;
    lsu_type_e dtype;
    logic      sign_ext;
  } lsu_ctrl_t;

endpackage

`default_nettype wire

// ==== lsu_settings.svh ====
/*
  widths of the load store unit, a 32-bit bus with byte enables only
  changing these alone does not make a wider unit: lane logic assumes 4 bytes
*/
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

////////////////////////////////
// bus geometry
////////////////////////////////

`define LSU_ADDR_W 32 // byte address
`define LSU_DATA_W 32 // one bus word

// derived from the data width, kept explicit for the package
`define LSU_BE_W   4  // one enable per byte lane
`define LSU_OFFS_W 2  // byte offset inside a word

`endif
